// ==== filelist.f ====
rtl/apb_delay_pkg.sv
rtl/delay_config_regs.sv
rtl/apb_delayer.sv
rtl/apb_sram_target.sv
rtl/apb_delay_top.sv
testbench/apb_delay_tb.sv

// ==== rtl/apb_delay_pkg.sv ====
package apb_delay_pkg;

    localparam int ratio_frac_bits  = 10;
    localparam int ratio_unity      = 1024;  // 1.0 in the ratio's fixed-point format
    localparam int ratio_width      = 16;
    localparam int wait_width       = 24;
    localparam int sram_depth_words = 256;

    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
        logic [2:0]  pprot;
        logic        pwrite;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_active = 2'd1,
        st_delay  = 2'd2
    } delay_state_t;

    typedef enum logic [1:0] {
        reg_enable    = 2'd0,
        reg_ratio     = 2'd1,
        reg_last_wait = 2'd2,
        reg_count     = 2'd3
    } cfg_addr_t;

endpackage

// ==== rtl/apb_delay_top.sv ====
`timescale 1ns/1ps

module apb_delay_top (
    input  logic                     clock,
    input  logic                     reset,
    input  apb_delay_pkg::apb_req_t  apb_req,
    output apb_delay_pkg::apb_rsp_t  apb_rsp,
    input  logic                     cfg_write,
    input  logic                     cfg_read,
    input  apb_delay_pkg::cfg_addr_t cfg_addr,
    input  logic [31:0]              cfg_wdata,
    output logic [31:0]              cfg_rdata
);
    import apb_delay_pkg::*;

    apb_req_t               target_req;
    apb_rsp_t               target_rsp;
    logic                   target_done;
    logic                   stretch_done;
    logic [wait_width-1:0]  measured_wait;
    logic                   stretch_enable;
    logic [ratio_width-1:0] stretch_ratio;

    apb_delayer delayer0 (
        .clock          (clock),
        .reset          (reset),
        .in_req         (apb_req),
        .in_rsp         (apb_rsp),
        .out_req        (target_req),
        .out_rsp        (target_rsp),
        .stretch_enable (stretch_enable),
        .stretch_ratio  (stretch_ratio),
        .target_done    (target_done),
        .measured_wait  (measured_wait),
        .stretch_done   (stretch_done)
    );

    delay_config_regs regs0 (
        .clock          (clock),
        .reset          (reset),
        .cfg_write      (cfg_write),
        .cfg_read       (cfg_read),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .cfg_rdata      (cfg_rdata),
        .target_done    (target_done),
        .stretch_done   (stretch_done),
        .measured_wait  (measured_wait),
        .stretch_enable (stretch_enable),
        .stretch_ratio  (stretch_ratio)
    );

    apb_sram_target sram0 (
        .clock (clock),
        .reset (reset),
        .req   (target_req),
        .rsp   (target_rsp)
    );

endmodule

// ==== rtl/apb_delayer.sv ====
`timescale 1ns/1ps

module apb_delayer (
    input  logic                                  clock,
    input  logic                                  reset,
    input  apb_delay_pkg::apb_req_t               in_req,
    output apb_delay_pkg::apb_rsp_t               in_rsp,
    output apb_delay_pkg::apb_req_t               out_req,
    input  apb_delay_pkg::apb_rsp_t               out_rsp,
    input  logic                                  stretch_enable,
    input  logic [apb_delay_pkg::ratio_width-1:0] stretch_ratio,
    output logic                                  target_done,
    output logic [apb_delay_pkg::wait_width-1:0]  measured_wait,
    output logic                                  stretch_done
);
    import apb_delay_pkg::*;

    delay_state_t                       state;
    logic [wait_width-1:0]              wait_cnt;
    logic [wait_width+ratio_width-1:0]  product_acc;  // Running W x ratio
    logic [wait_width-1:0]              delay_cnt;
    logic [wait_width-1:0]              scaled_wait;
    logic [31:0]                        held_prdata;
    logic                               held_pslverr;
    logic                               setup_cycle;
    logic                               release_rsp;

    assign setup_cycle = in_req.psel && !in_req.penable;
    assign target_done = (state == st_active) && out_rsp.pready;
    assign release_rsp = (state == st_delay) && (delay_cnt == '0);

    // Drop the fractional bits to get floor(W x ratio / 1024)
    assign scaled_wait = product_acc[ratio_frac_bits +: wait_width];

    assign measured_wait = wait_cnt;
    assign stretch_done  = release_rsp;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (setup_cycle) begin
                        state <= st_active;
                    end
                end
                st_active: begin
                    if (out_rsp.pready) begin
                        state <= stretch_enable ? st_delay : st_idle;
                    end
                end
                st_delay: begin
                    if (delay_cnt == '0) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wait_cnt    <= '0;
            product_acc <= '0;
            delay_cnt   <= '0;
        end else begin
            if ((state == st_active) && !out_rsp.pready) begin
                wait_cnt    <= wait_cnt + 1'b1;
                product_acc <= product_acc + {{wait_width{1'b0}}, stretch_ratio};
            end else if (target_done) begin
                wait_cnt    <= '0;
                product_acc <= '0;
                delay_cnt   <= scaled_wait - wait_cnt;  // Extra cycles beyond the target's own
            end else if ((state == st_delay) && (delay_cnt != '0)) begin
                delay_cnt <= delay_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (target_done) begin
            held_prdata  <= out_rsp.prdata;
            held_pslverr <= out_rsp.pslverr;
        end
    end

    // Keep the target from seeing a second access while the response is held
    always_comb begin
        out_req = in_req;
        if (state == st_delay) begin
            out_req.psel    = 1'b0;
            out_req.penable = 1'b0;
        end
    end

    always_comb begin
        if (stretch_enable) begin
            in_rsp.pready  = release_rsp;
            in_rsp.prdata  = release_rsp ? held_prdata : 32'd0;
            in_rsp.pslverr = release_rsp && held_pslverr;
        end else begin
            in_rsp = out_rsp;
        end
    end

endmodule

// ==== rtl/apb_sram_target.sv ====
`timescale 1ns/1ps

module apb_sram_target (
    input  logic                    clock,
    input  logic                    reset,
    input  apb_delay_pkg::apb_req_t req,
    output apb_delay_pkg::apb_rsp_t rsp
);
    import apb_delay_pkg::*;

    logic [31:0] mem [sram_depth_words];
    logic [2:0]  wait_cnt;
    logic [2:0]  wait_target;
    logic [7:0]  word_idx;
    logic        access;
    logic        done;
    logic        in_range;

    assign access      = req.psel && req.penable;
    assign wait_target = req.paddr[4:2];  // Slower words sit at higher offsets in a line
    assign word_idx    = req.paddr[9:2];
    assign in_range    = req.paddr < 32'(sram_depth_words * 4);
    assign done        = access && (wait_cnt == wait_target);

    always_ff @(posedge clock) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (!access || done) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 3'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (done && req.pwrite && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (req.pstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= req.pwdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp.pready  = done;
        rsp.pslverr = done && !in_range;
        if (done && !req.pwrite && in_range) begin
            rsp.prdata = mem[word_idx];
        end else begin
            rsp.prdata = 32'd0;
        end
    end

endmodule

// ==== rtl/delay_config_regs.sv ====
`timescale 1ns/1ps

module delay_config_regs (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  cfg_write,
    input  logic                                  cfg_read,
    input  apb_delay_pkg::cfg_addr_t              cfg_addr,
    input  logic [31:0]                           cfg_wdata,
    output logic [31:0]                           cfg_rdata,
    input  logic                                  target_done,
    input  logic                                  stretch_done,
    input  logic [apb_delay_pkg::wait_width-1:0]  measured_wait,
    output logic                                  stretch_enable,
    output logic [apb_delay_pkg::ratio_width-1:0] stretch_ratio
);
    import apb_delay_pkg::*;

    logic [wait_width-1:0]  last_wait;
    logic [31:0]            stretch_count;
    logic [ratio_width-1:0] ratio_wdata;
    logic [31:0]            read_mux;

    assign ratio_wdata = cfg_wdata[ratio_width-1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            stretch_enable <= 1'b0;
            stretch_ratio  <= ratio_width'(ratio_unity);
        end else if (cfg_write) begin
            if (cfg_addr == reg_enable) begin
                stretch_enable <= cfg_wdata[0];
            end
            if (cfg_addr == reg_ratio) begin
                // A ratio below one would shorten transfers
                if (ratio_wdata < ratio_width'(ratio_unity)) begin
                    stretch_ratio <= ratio_width'(ratio_unity);
                end else begin
                    stretch_ratio <= ratio_wdata;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            last_wait     <= '0;
            stretch_count <= '0;
        end else begin
            if (target_done) begin
                last_wait <= measured_wait;
            end
            if (cfg_write && cfg_addr == reg_count) begin
                stretch_count <= '0;  // Clear wins over a coincident pulse
            end else if (stretch_done) begin
                stretch_count <= stretch_count + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            reg_enable:    read_mux = {31'd0, stretch_enable};
            reg_ratio:     read_mux = {{(32 - ratio_width){1'b0}}, stretch_ratio};
            reg_last_wait: read_mux = {{(32 - wait_width){1'b0}}, last_wait};
            default:       read_mux = stretch_count;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cfg_rdata <= '0;
        end else if (cfg_read) begin
            cfg_rdata <= read_mux;
        end
    end

endmodule

// ==== testbench/apb_delay_tb.sv ====
`timescale 1ns/1ps

module apb_delay_tb;
    import apb_delay_pkg::*;

    localparam int n_fill    = 256;
    localparam int n_plain   = 64;
    localparam int n_stretch = 128;
    localparam int n_tail    = 8;
    localparam int max_transfer_cycles = 31;  // Setup, 29 stretched access cycles, idle
    // Random transfers may add a read-back, so they count twice
    localparam int timeout_cycles =
        (n_fill + 2 * (n_plain + n_stretch + n_tail)) * max_transfer_cycles + 1000;
    localparam int kind_data    = 0;
    localparam int kind_latency = 1;
    localparam int kind_config  = 2;

    logic        clock;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        cfg_write;
    logic        cfg_read;
    cfg_addr_t   cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;

    logic [15:0] lfsr = 16'd60;
    logic [31:0] mem_model [256];
    logic [31:0] last_cfg_rdata = '0;
    logic        stretch_on = 1'b0;
    int          ratio_shadow = 1024;
    int          last_wait_shadow = 0;
    int          count_shadow = 0;
    int          error_counts [3] = '{0, 0, 0};
    int          cycle_count = 0;

    apb_delay_top dut0 (
        .clock     (clock),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .cfg_write (cfg_write),
        .cfg_read  (cfg_read),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < width; i++) begin
            feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr     = {lfsr[14:0], feedback};
            value    = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [31:0] fill_word(input int index);
        logic [7:0] i8;
        i8 = index[7:0];
        return {i8, ~i8, i8 ^ 8'h5a, 8'hc3 ^ {i8[3:0], i8[7:4]}};
    endfunction

    task automatic check_value(input string name, input int kind,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
            error_counts[kind]++;
        end
    endtask

    task automatic write_config(input cfg_addr_t addr, input logic [31:0] data);
        @(negedge clock);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clock);
        cfg_write = 1'b0;
    endtask

    task automatic read_config(input string name, input cfg_addr_t addr,
                               input logic [31:0] expected);
        @(negedge clock);
        cfg_read = 1'b1;
        cfg_addr = addr;
        #5;
        check_value({name, "_early"}, kind_config, last_cfg_rdata, cfg_rdata);  // Not yet updated
        @(negedge clock);
        cfg_read = 1'b0;
        check_value(name, kind_config, expected, cfg_rdata);
        last_cfg_rdata = cfg_rdata;
    endtask

    task automatic apb_transfer(input logic [31:0] addr, input logic write,
                                input logic [31:0] wdata, input logic [3:0] strb,
                                output logic [31:0] rdata, output logic slverr,
                                output int cycles);
        logic seen;
        @(negedge clock);
        apb_req.paddr   = addr;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pprot   = 3'd0;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.pstrb   = strb;
        @(negedge clock);
        apb_req.penable = 1'b1;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            #5;  // Sample mid cycle
            cycles++;
            if (apb_rsp.pready) begin
                rdata  = apb_rsp.prdata;
                slverr = apb_rsp.pslverr;
                seen   = 1'b1;
            end
            @(negedge clock);
        end
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic run_transfer(input logic [31:0] addr, input logic write,
                                input logic [31:0] wdata, input logic [3:0] strb);
        logic [31:0] rdata;
        logic [31:0] expected_rdata;
        logic        slverr;
        logic        valid;
        int          cycles;
        int          expected_cycles;
        int          w;
        w     = addr[4:2];
        valid = addr < 32'd1024;
        expected_cycles = stretch_on ? (w * ratio_shadow / 1024 + 2) : (w + 1);
        expected_rdata  = (valid && !write) ? mem_model[addr[9:2]] : 32'd0;
        apb_transfer(addr, write, wdata, strb, rdata, slverr, cycles);
        check_value(stretch_on ? "stretched_latency" : "pass_through_latency", kind_latency,
                    expected_cycles, cycles);
        check_value(valid ? "memory_read" : "error_read", kind_data, expected_rdata, rdata);
        check_value("error_response", kind_data, !valid, slverr);
        if (valid && write) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    mem_model[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        last_wait_shadow = w;
        if (stretch_on) begin
            count_shadow++;
        end
    endtask

    task automatic random_transfer();
        logic [31:0] addr;
        logic        write;
        addr  = random_bits(8) << 2;
        if (random_bits(3) == 0) begin
            addr = addr | ((random_bits(4) + 1) << 10);  // Outside the SRAM
        end
        write = random_bits(1);
        run_transfer(addr, write, random_bits(32), random_bits(4));
        if (addr >= 32'd1024 && write) begin
            run_transfer(addr & 32'h0000_03fc, 1'b0, 32'd0, 4'd0);  // Word must be unchanged
        end
    endtask

    initial begin
        apb_req   = '0;
        cfg_write = 1'b0;
        cfg_read  = 1'b0;
        cfg_addr  = reg_enable;
        cfg_wdata = '0;
        reset     = 1'b1;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        read_config("reset_enable", reg_enable, 32'd0);
        read_config("reset_ratio", reg_ratio, 32'd1024);
        read_config("reset_last_wait", reg_last_wait, 32'd0);
        read_config("reset_count", reg_count, 32'd0);

        for (int i = 0; i < n_fill; i++) begin
            run_transfer(i * 4, 1'b1, fill_word(i), 4'hf);
        end
        for (int i = 0; i < n_plain; i++) begin
            random_transfer();
            if (i % 8 == 7) begin
                read_config("last_wait", reg_last_wait, last_wait_shadow);
            end
        end

        write_config(reg_ratio, random_bits(10));
        read_config("ratio_clamp", reg_ratio, 32'd1024);

        write_config(reg_count, 32'd0);
        write_config(reg_enable, 32'd1);
        stretch_on   = 1'b1;
        count_shadow = 0;
        for (int i = 0; i < n_stretch; i++) begin
            if (i % 16 == 0) begin
                ratio_shadow = random_bits(12);
                if (ratio_shadow < 1024) begin
                    ratio_shadow = ratio_shadow + 1024;
                end
                write_config(reg_ratio, ratio_shadow);
                read_config("ratio", reg_ratio, ratio_shadow);
            end
            random_transfer();
            if (i % 16 == 15) begin
                read_config("last_wait", reg_last_wait, last_wait_shadow);
                read_config("stretch_count", reg_count, count_shadow);
            end
        end

        write_config(reg_enable, 32'd0);
        stretch_on = 1'b0;
        for (int i = 0; i < n_tail; i++) begin
            random_transfer();
        end
        read_config("stretch_count_held", reg_count, count_shadow);

        write_config(reg_count, 32'd0);
        count_shadow = 0;
        read_config("stretch_count_clear", reg_count, count_shadow);

        $display("Errors: data %0d, latency %0d, config %0d",
                 error_counts[kind_data], error_counts[kind_latency], error_counts[kind_config]);
        if (error_counts[kind_data] + error_counts[kind_latency]
                + error_counts[kind_config] == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
